//--- vlog.f
+incdir+.
conv_pkg.sv
conv_window.sv
conv_filter.sv
conv_activation.sv
conv_layer_top.sv
conv_layer_sva.sv
conv_layer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module conv_layer_tb -o conv_layer_sim \
	&& ./obj_dir/conv_layer_sim | tee /dev/stderr | grep -qx "sim passed" \
	&& { echo "RESULT: PASS"; exit 0; } \
	|| { echo "RESULT: FAIL"; exit 1; }

//--- conv_layer_tb.sv
`include "conv_consts.svh"

module conv_layer_tb;
	import conv_pkg::*;

	localparam int     img_w       = `CONV_IMG_W;
	localparam int     img_h       = `CONV_IMG_H;
	localparam bit     relu_en     = 1'b1;
	localparam int     per_frame   = (img_w - `CONV_K + 1) * (img_h - `CONV_K + 1);
	localparam int     drain_limit = 64;
	localparam longint data_max    = (longint'(1) <<< (`CONV_DATA_W - 1)) - 1;
	localparam longint data_min    = -(longint'(1) <<< (`CONV_DATA_W - 1));

	// filter 0 sums its window, filter 1 negates it, filter 2 overdrives it.
	// the rest get small weights of both signs.
	function automatic kernel_set_t make_weights();
		kernel_set_t ks;
		for (int f = 0; f < `CONV_OUT_CH; f++) begin
			for (int c = 0; c < `CONV_IN_CH; c++) begin
				for (int t = 0; t < `CONV_TAPS; t++) begin
					if (f == 0) begin
						ks.k[f].w[c][t] = data_t'(1);
					end else if (f == 1) begin
						ks.k[f].w[c][t] = data_t'(-1);
					end else if (f == 2) begin
						ks.k[f].w[c][t] = data_t'(1000);
					end else begin
						ks.k[f].w[c][t] = data_t'(((f * 5 + c * 3 + t * 7) % 9) - 4);
					end
				end
			end
		end
		return ks;
	endfunction

	function automatic bias_set_t make_biases();
		bias_set_t bs;
		for (int f = 0; f < `CONV_OUT_CH; f++) begin
			bs.b[f] = (f % 2 == 0) ? data_t'(f * 5 + 3) : data_t'(-(f * 4 + 5));
		end
		return bs;
	endfunction

	localparam kernel_set_t weights = make_weights();
	localparam bias_set_t   biases  = make_biases();

	logic    clk;
	logic    rst;
	logic    valid_in;
	pixel_t  pixel_in;
	logic    out_valid;
	result_t result;

	pixel_t  img [img_h][img_w];
	pixel_t  saved_img [img_h][img_w];
	result_t exp_q [$];
	result_t seen_q [$];
	result_t ref_q [$];
	result_t exp_now;
	integer  seed = 32'h8179;
	int      errors = 0;
	int      checked = 0;
	int      tests_run = 0;

	conv_layer_top #(
		.img_w(img_w),
		.img_h(img_h),
		.relu_en(relu_en),
		.weights(weights),
		.biases(biases)
	) UUT (
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.pixel_in(pixel_in),
		.out_valid(out_valid),
		.result(result)
	);

	always #2 clk = ~clk;

	// the window ending at (r, c) starts K-1 rows up and K-1 columns left.
	function automatic result_t model_result(int r, int c);
		result_t e;
		longint  s;
		for (int f = 0; f < `CONV_OUT_CH; f++) begin
			s = longint'($signed(biases.b[f]));
			for (int ch = 0; ch < `CONV_IN_CH; ch++) begin
				for (int dr = 0; dr < `CONV_K; dr++) begin
					for (int dc = 0; dc < `CONV_K; dc++) begin
						s += longint'($signed(img[r - `CONV_K + 1 + dr][c - `CONV_K + 1 + dc].ch[ch]))
							* longint'($signed(weights.k[f].w[ch][dr * `CONV_K + dc]));
					end
				end
			end
			if (relu_en && s < 0) begin
				s = 0;
			end
			if (s > data_max) begin
				s = data_max;
			end else if (s < data_min) begin
				s = data_min;
			end
			e.res[f] = data_t'(s);
		end
		return e;
	endfunction

	// mode 0 is all ones, 1 small signed, 2 small positive, 3 near full scale.
	task automatic fill_image(input int mode);
		for (int r = 0; r < img_h; r++) begin
			for (int c = 0; c < img_w; c++) begin
				for (int ch = 0; ch < `CONV_IN_CH; ch++) begin
					case (mode)
						0: img[r][c].ch[ch] = data_t'(1);
						1: img[r][c].ch[ch] = data_t'($random(seed) % 200);
						2: img[r][c].ch[ch] = data_t'(($random(seed) & 32'h7f) + 1);
						default: img[r][c].ch[ch] = data_t'(30000 + ($random(seed) & 32'h3ff));
					endcase
				end
			end
		end
	endtask

	task automatic send_frame(input bit gaps);
		for (int r = 0; r < img_h; r++) begin
			for (int c = 0; c < img_w; c++) begin
				while (gaps && (($random(seed) & 3) == 0)) begin
					@(posedge clk);
					valid_in <= 1'b0;
				end
				@(posedge clk);
				valid_in <= 1'b1;
				pixel_in <= img[r][c];
				if (r >= `CONV_K - 1 && c >= `CONV_K - 1) begin
					exp_q.push_back(model_result(r, c));
				end
			end
		end
	endtask

	task automatic end_stream();
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < drain_limit) begin
			@(posedge clk);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("timeout: %0d results still pending after %0d cycles", exp_q.size(), n);
			exp_q.delete();
		end
	endtask

	task automatic check_count(input int want);
		assert (seen_q.size() == want) else begin
			errors++;
			$display("MISMATCH at %0t: %0d outputs, expected %0d", $time, seen_q.size(), want);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		$display("%s: done, %0d errors", name, errors - errs_before);
	endtask

	task automatic ones_frame();
		int e0;
		e0 = errors;
		assert (out_valid == 1'b0 && result == '0) else begin
			errors++;
			$display("MISMATCH at %0t: outputs not cleared by reset", $time);
		end
		fill_image(0);
		seen_q.delete();
		send_frame(1'b0);
		end_stream();
		wait_drain();
		check_count(per_frame);
		report_test("all-ones frame", e0);
	endtask

	task automatic random_frame();
		int e0;
		e0 = errors;
		fill_image(1);
		saved_img = img;
		// the model's gapless results of this frame, in raster order.
		ref_q.delete();
		for (int r = `CONV_K - 1; r < img_h; r++) begin
			for (int c = `CONV_K - 1; c < img_w; c++) begin
				ref_q.push_back(model_result(r, c));
			end
		end
		seen_q.delete();
		send_frame(1'b0);
		end_stream();
		wait_drain();
		check_count(per_frame);
		report_test("random frame", e0);
	endtask

	task automatic relu_clamp();
		int e0;
		e0 = errors;
		fill_image(2);
		seen_q.delete();
		send_frame(1'b0);
		end_stream();
		wait_drain();
		// filter 1 has only negative weights and bias, so its sum is always below zero.
		foreach (seen_q[i]) begin
			assert (seen_q[i].res[1] == '0) else begin
				errors++;
				$display("MISMATCH at %0t: output %0d of filter 1 is %0d, expected 0",
					$time, i, seen_q[i].res[1]);
			end
		end
		report_test("relu clamp", e0);
	endtask

	task automatic saturation_pin();
		int e0;
		e0 = errors;
		fill_image(3);
		seen_q.delete();
		send_frame(1'b0);
		end_stream();
		wait_drain();
		foreach (seen_q[i]) begin
			assert (longint'(seen_q[i].res[2]) == data_max) else begin
				errors++;
				$display("MISMATCH at %0t: output %0d of filter 2 is %0d, expected %0d",
					$time, i, seen_q[i].res[2], data_max);
			end
		end
		report_test("saturation", e0);
	endtask

	task automatic gapped_frames();
		int e0;
		e0 = errors;
		img = saved_img;
		seen_q.delete();
		send_frame(1'b1);
		fill_image(1);
		send_frame(1'b1);
		end_stream();
		wait_drain();
		check_count(2 * per_frame);
		// the first frame repeats the random frame, now with gaps.
		for (int i = 0; i < per_frame && i < seen_q.size() && i < ref_q.size(); i++) begin
			assert (seen_q[i] == ref_q[i]) else begin
				errors++;
				$display("MISMATCH at %0t: gapped output %0d differs from the gapless run",
					$time, i);
			end
		end
		report_test("gapped frames", e0);
	endtask

	always @(posedge clk) begin
		if (!rst && out_valid) begin
			seen_q.push_back(result);
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("unexpected output at time %0t with no result pending", $time);
			end
			if (exp_q.size() != 0) begin
				exp_now = exp_q.pop_front();
				checked++;
				assert (result == exp_now) else begin
					errors++;
					$display("MISMATCH at %0t: result %h, expected %h", $time, result, exp_now);
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		valid_in = 1'b0;
		pixel_in = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		ones_frame();
		random_frame();
		relu_clamp();
		saturation_pin();
		gapped_frames();
		// a few idle cycles let a stray output reach the monitor.
		repeat (8) @(posedge clk);
		$display("%0d tests, %0d outputs checked, %0d errors", tests_run, checked, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- conv_layer_sva.sv
`include "conv_consts.svh"

module conv_layer_sva #(
	parameter int img_w = `CONV_IMG_W,
	parameter int img_h = `CONV_IMG_H
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input logic win_valid,
	input logic out_valid
);
	// raster position of the pixel on the input, tracked apart from the DUT.
	int   col;
	int   row;
	logic qual;

	assign qual = valid_in && (col >= `CONV_K - 1) && (row >= `CONV_K - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= 0;
			row <= 0;
		end else if (valid_in) begin
			if (col == img_w - 1) begin
				col <= 0;
				row <= (row == img_h - 1) ? 0 : row + 1;
			end else begin
				col <= col + 1;
			end
		end
	end

	reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high while reset is applied");

	reset_exit: assert property (@(posedge clk)
		$fell(rst) |-> !out_valid ##1 !out_valid ##1 !out_valid ##1 !out_valid)
		else $error("out_valid high with the pipeline still empty after reset");

	out_latency: assert property (@(posedge clk) disable iff (rst) qual |-> ##4 out_valid)
		else $error("no out_valid four cycles after a full window");

	out_source: assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(qual, 4))
		else $error("out_valid without a full window four cycles before");

	win_column: assert property (@(posedge clk) disable iff (rst)
		win_valid |-> $past(valid_in) && ($past(col) >= `CONV_K - 1))
		else $error("win_valid for a pixel in column 0 or 1");

endmodule

bind conv_layer_top conv_layer_sva #(
	.img_w(img_w),
	.img_h(img_h)
) u_sva (
	.clk(clk),
	.rst(rst),
	.valid_in(valid_in),
	.win_valid(win_valid),
	.out_valid(out_valid)
);

//--- conv_layer_top.sv
`include "conv_consts.svh"

module conv_layer_top #(
	parameter int                    img_w   = `CONV_IMG_W,
	parameter int                    img_h   = `CONV_IMG_H,
	parameter bit                    relu_en = 1'b1,
	parameter conv_pkg::kernel_set_t weights = '0,
	parameter conv_pkg::bias_set_t   biases  = '0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid_in,
	input  conv_pkg::pixel_t  pixel_in,
	output logic              out_valid,
	output conv_pkg::result_t result
);
	import conv_pkg::*;

	window_t                 win;
	logic                    win_valid;
	wire acc_vec_t           acc_vec;
	wire [`CONV_OUT_CH-1:0]  acc_valid;

	conv_window #(
		.img_w(img_w),
		.img_h(img_h)
	) u_window (
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.pixel_in(pixel_in),
		.win(win),
		.win_valid(win_valid)
	);

	// every filter sees the same window and differs only in its weights.
	for (genvar i = 0; i < `CONV_OUT_CH; i++) begin : g_filter
		conv_filter #(
			.weights(weights.k[i]),
			.bias(biases.b[i])
		) u_filter (
			.clk(clk),
			.rst(rst),
			.win_valid(win_valid),
			.win(win),
			.acc(acc_vec.acc[i]),
			.acc_valid(acc_valid[i])
		);
	end

	// the filters run in lock step, so the valid of filter 0 stands for all.
	conv_activation #(
		.relu_en(relu_en)
	) u_activation (
		.clk(clk),
		.rst(rst),
		.acc_valid(acc_valid[0]),
		.acc_vec(acc_vec),
		.out_valid(out_valid),
		.result(result)
	);

endmodule

//--- conv_activation.sv
`include "conv_consts.svh"

module conv_activation #(
	parameter bit relu_en = 1'b0
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               acc_valid,
	input  conv_pkg::acc_vec_t acc_vec,
	output logic               out_valid,
	output conv_pkg::result_t  result
);
	import conv_pkg::*;

	// limits of data_t, widened to the accumulator.
	localparam data_t data_max = data_t'({1'b0, {(`CONV_DATA_W-1){1'b1}}});
	localparam data_t data_min = data_t'({1'b1, {(`CONV_DATA_W-1){1'b0}}});
	localparam acc_t  sat_max  = acc_t'(data_max);
	localparam acc_t  sat_min  = acc_t'(data_min);

	result_t clipped;

	always_comb begin
		acc_t v;
		for (int i = 0; i < `CONV_OUT_CH; i++) begin
			v = acc_vec.acc[i];
			// relu comes first, so saturation only ever meets its output.
			if (relu_en && (v < 0)) begin
				v = '0;
			end
			if (v > sat_max) begin
				clipped.res[i] = data_max;
			end else if (v < sat_min) begin
				clipped.res[i] = data_min;
			end else begin
				clipped.res[i] = data_t'(v);
			end
		end
	end

	// result keeps the last set of values until the next pulse.
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			result    <= '0;
		end else begin
			out_valid <= acc_valid;
			if (acc_valid) begin
				result <= clipped;
			end
		end
	end

endmodule

//--- conv_filter.sv
`include "conv_consts.svh"

module conv_filter #(
	parameter conv_pkg::kernel_t weights = '0,
	parameter conv_pkg::data_t   bias    = '0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              win_valid,
	input  conv_pkg::window_t win,
	output conv_pkg::acc_t    acc,
	output logic              acc_valid
);
	import conv_pkg::*;

	// a full product of two samples.
	typedef logic signed [2*`CONV_DATA_W-1:0] prod_t;

	prod_t prod_d [`CONV_IN_CH][`CONV_TAPS];
	prod_t prod_q [`CONV_IN_CH][`CONV_TAPS];
	logic  prod_valid;
	acc_t  sum;

	// both operands are widened with their sign before the multiply.
	always_comb begin
		for (int c = 0; c < `CONV_IN_CH; c++) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				prod_d[c][t] = prod_t'(win.tap[c][t]) * prod_t'(weights.w[c][t]);
			end
		end
	end

	// stage one holds all 36 products.
	always_ff @(posedge clk) begin
		if (win_valid) begin
			prod_q <= prod_d;
		end
	end

	// the bias is the starting value of the adder tree.
	always_comb begin
		sum = acc_t'(bias);
		for (int c = 0; c < `CONV_IN_CH; c++) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				sum = sum + acc_t'(prod_q[c][t]);
			end
		end
	end

	// stage two holds the finished sum.
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			acc <= sum;
		end
	end

	// the valid runs beside the data, so a new window may enter every cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			acc_valid  <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			acc_valid  <= prod_valid;
		end
	end

endmodule

//--- conv_window.sv
`include "conv_consts.svh"

module conv_window #(
	parameter int img_w = `CONV_IMG_W,
	parameter int img_h = `CONV_IMG_H
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid_in,
	input  conv_pkg::pixel_t  pixel_in,
	output conv_pkg::window_t win,
	output logic              win_valid
);
	import conv_pkg::*;

	localparam int col_w = (img_w > 1) ? $clog2(img_w) : 1;
	localparam int row_w = (img_h > 1) ? $clog2(img_h) : 1;

	// raster position of the pixel now on pixel_in.
	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	logic             col_last;
	logic             row_last;
	logic             in_range;

	// line_prev holds the previous row and line_prev2 the row before it.
	// both are addressed by column, so one read and one write per pixel.
	pixel_t line_prev  [img_w];
	pixel_t line_prev2 [img_w];
	pixel_t above1;
	pixel_t above2;

	// the column entering the window, top row first.
	pixel_t fresh [`CONV_K];

	assign col_last = (col == col_w'(img_w - 1));
	assign row_last = (row == row_w'(img_h - 1));

	// a full window exists only once K-1 columns and rows lie behind the pixel.
	assign in_range = (col >= col_w'(`CONV_K - 1)) && (row >= row_w'(`CONV_K - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			col       <= '0;
			row       <= '0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= valid_in && in_range;
			if (valid_in) begin
				if (col_last) begin
					col <= '0;
					// the next frame starts right after the last pixel.
					if (row_last) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign above1 = line_prev[col];
	assign above2 = line_prev2[col];

	// each line buffer entry ages by one row whenever its column is visited.
	always_ff @(posedge clk) begin
		if (valid_in) begin
			line_prev[col]  <= pixel_in;
			line_prev2[col] <= above1;
		end
	end

	always_comb begin
		fresh[0] = above2;
		fresh[1] = above1;
		fresh[2] = pixel_in;
	end

	// the window register is a 3x3 shift register per channel.
	// on every pixel each row moves one tap left and the fresh column
	// enters on the right, so it always ends at the last pixel taken.
	always_ff @(posedge clk) begin
		if (valid_in) begin
			for (int c = 0; c < `CONV_IN_CH; c++) begin
				for (int r = 0; r < `CONV_K; r++) begin
					for (int k = 0; k < `CONV_K - 1; k++) begin
						win.tap[c][r*`CONV_K + k] <= win.tap[c][r*`CONV_K + k + 1];
					end
					win.tap[c][r*`CONV_K + `CONV_K - 1] <= fresh[r].ch[c];
				end
			end
		end
	end

endmodule

//--- conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

	// one signed sample.
	typedef logic signed [`CONV_DATA_W-1:0] data_t;

	// one signed accumulator.
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// one pixel, indexed by input channel.
	typedef struct packed {
		data_t [`CONV_IN_CH-1:0] ch;
	} pixel_t;

	// a 3x3 window for every input channel.
	// tap 0 is the top-left sample and taps run in row-major order.
	typedef struct packed {
		data_t [`CONV_IN_CH-1:0][`CONV_TAPS-1:0] tap;
	} window_t;

	// the weights of one filter, laid out exactly like window_t.
	typedef struct packed {
		data_t [`CONV_IN_CH-1:0][`CONV_TAPS-1:0] w;
	} kernel_t;

	// the weights of all filters, indexed by output channel.
	typedef struct packed {
		kernel_t [`CONV_OUT_CH-1:0] k;
	} kernel_set_t;

	// one bias per filter.
	typedef struct packed {
		data_t [`CONV_OUT_CH-1:0] b;
	} bias_set_t;

	// raw sums of all filters before activation.
	typedef struct packed {
		acc_t [`CONV_OUT_CH-1:0] acc;
	} acc_vec_t;

	// final outputs of all filters.
	typedef struct packed {
		data_t [`CONV_OUT_CH-1:0] res;
	} result_t;

endpackage

//--- conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// channel counts of the layer.
`define CONV_IN_CH 4
`define CONV_OUT_CH 12

// the kernel is square, so a window holds CONV_K rows of CONV_K taps.
`define CONV_K 3
`define CONV_TAPS (`CONV_K * `CONV_K)

// samples are signed integers.
`define CONV_DATA_W 16

// 36 full-scale products plus a bias need 37 bits, so 40 leaves headroom.
`define CONV_ACC_W 40

// default image geometry.
`define CONV_IMG_W 6
`define CONV_IMG_H 6

`endif
